// ==== bench/jump_props.sv ====
`include "jump_settings.svh"

module jump_props (
  input logic                    clk,
  input logic                    reset_i,
  input logic                    redirect_valid_i,
  input logic                    redirect_ready_i,
  input logic [`JUMP_ADDR_W-1:0] next_eip_i,
  input logic [`JUMP_ADDR_W-1:0] target_i,
  input logic [`JUMP_ADDR_W-1:0] seg_i,
  input logic                    load_address_i,
  input logic                    load_cs_i,
  input logic                    mispredict_i
);

  logic [3*`JUMP_ADDR_W+2:0] payload;

  assign payload = {next_eip_i, target_i, seg_i, load_address_i, load_cs_i, mispredict_i};

  // ========================================
  // a stalled redirect keeps valid and payload.
  a_stall_stable: assert property (@(posedge clk) disable iff (reset_i)
    redirect_valid_i && !redirect_ready_i |=> redirect_valid_i && $stable(payload))
    else $error("redirect valid or payload changed while stalled");

  a_reset_idle: assert property (@(posedge clk) reset_i |=> !redirect_valid_i)
    else $error("redirect valid high in the cycle after reset");

  // a far jump always loads eip too.
  a_cs_needs_eip: assert property (@(posedge clk) disable iff (reset_i)
    redirect_valid_i && load_cs_i |-> load_address_i)
    else $error("load_cs without load_address");

endmodule

bind jump_subsystem jump_props u_jump_props (
  .clk              (clk),
  .reset_i          (reset_i),
  .redirect_valid_i (redirect_valid_o),
  .redirect_ready_i (redirect_ready_i),
  .next_eip_i       (redirect_next_eip_o),
  .target_i         (redirect_target_o),
  .seg_i            (redirect_seg_o),
  .load_address_i   (redirect_load_address_o),
  .load_cs_i        (redirect_load_cs_o),
  .mispredict_i     (redirect_mispredict_o)
);

// ==== bench/jump_tb.sv ====
`include "jump_settings.svh"

module jump_tb;

  localparam int NUM_FIXED = 16;
  localparam int NUM_SWEEP = 32;
  localparam int NUM_ROWS = 54;
  localparam int TIMEOUT = NUM_ROWS * 40 + 200;
  localparam logic [31:0] NEXT_EIP = 32'h0000_1230;
  localparam logic [31:0] FAR_SEG = 32'h0000_2000;

  logic                    clk;
  logic                    reset_i;
  logic                    op_valid_i;
  logic                    op_ready_o;
  logic [`JUMP_ADDR_W-1:0] op_next_eip_i;
  logic [`JUMP_ADDR_W-1:0] op_op0_i;
  logic [`JUMP_ADDR_W-1:0] op_seg_i;
  logic [15:0]             op_opcode_i;
  logic [2:0]              op_opsize_i;
  logic [2:0]              op_alu_op_i;
  logic                    op_zf_en_i;
  logic                    op_cf_en_i;
  logic                    op_predicted_taken_i;
  logic                    flags_we_i;
  logic                    zf_i;
  logic                    cf_i;
  logic                    redirect_valid_o;
  logic                    redirect_ready_i;
  logic [`JUMP_ADDR_W-1:0] redirect_next_eip_o;
  logic [`JUMP_ADDR_W-1:0] redirect_target_o;
  logic [`JUMP_ADDR_W-1:0] redirect_seg_o;
  logic                    redirect_load_address_o;
  logic                    redirect_load_cs_o;
  logic                    redirect_mispredict_o;
  logic [`JUMP_ADDR_W-1:0] eip_o;
  logic [`JUMP_ADDR_W-1:0] cs_o;
  logic [`JUMP_CNT_W-1:0]  mispredict_count_o;

  // stimulus table, flags are {write, zf, cf}.
  string               row_name [NUM_ROWS];
  logic [2:0]          row_flags [NUM_ROWS];
  jump_pkg::jump_op_t  row_op [NUM_ROWS];
  jump_pkg::redirect_t row_exp [NUM_ROWS];

  int          n_rows;
  int          out_count;
  int          errors;
  logic [31:0] rng_state;
  logic        cur_zf;
  logic        cur_cf;
  logic [31:0] m_eip;
  logic [31:0] m_cs;
  logic [15:0] m_count;

  jump_subsystem DUT (.*);

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1103515245 + 32'd12345;
  endfunction

  // ========================================
  // reference model of the resolution rules.
  function automatic jump_pkg::redirect_t model_resolve(input jump_pkg::jump_op_t op,
                                                       input logic zf, input logic cf);
    jump_pkg::redirect_t r;
    logic [7:0]          opc;
    logic                jcc;
    logic                uncond;
    logic                cnd;
    opc = op.opcode[15:8];
    jcc = (opc == 8'h75) || (opc == 8'h77) || (opc == 8'h0F);
    uncond = (opc == 8'hEB) || (opc == 8'hE9) || (opc == 8'hEA) ||
             ((opc == 8'hFF) && (op.alu_op == 3'd6));
    cnd = (op.zf_en && !op.cf_en && !zf) || (!zf && !cf);
    r = '0;
    r.next_eip = op.next_eip;
    r.load_address = jcc ? cnd : uncond;
    r.load_cs = (opc == 8'hEA);
    r.seg = r.load_cs ? op.seg : 32'h0;
    if (r.load_address) begin
      r.target = ((opc == 8'hFF) || (opc == 8'hEA)) ? op.op0 : op.next_eip + op.op0;
    end
    case (op.opsize)
      3'd1: r.target = r.target & 32'h0000_00FF;
      3'd2: r.target = r.target & 32'h0000_FFFF;
      3'd3: r.target = r.target;
      default: r.target = 32'h0;
    endcase
    r.mispredict = jcc ? (cnd ^ op.predicted_taken) : (uncond && !op.predicted_taken);
    return r;
  endfunction

  task automatic add_row(input string name, input logic [2:0] flags, input logic [15:0] opc,
                         input int sz, input int alu, input logic [1:0] en, input int pred,
                         input logic [31:0] op0, input logic [31:0] tgt, input logic [2:0] bits);
    row_name[n_rows] = name;
    row_flags[n_rows] = flags;
    row_op[n_rows] = '{NEXT_EIP, op0, FAR_SEG, opc, jump_pkg::opsize_e'(sz[2:0]),
                       alu[2:0], en[1], en[0], pred[0]};
    row_exp[n_rows] = '{NEXT_EIP, tgt, bits[1] ? FAR_SEG : 32'h0, bits[2], bits[1], bits[0]};
    if (flags[2]) begin
      cur_zf = flags[1];
      cur_cf = flags[0];
    end
    n_rows++;
  endtask

  // every zf, cf, zf_en and cf_en combination for jne and jnbe.
  task automatic add_cond_sweep();
    jump_pkg::jump_op_t op;
    for (int f = 3; f >= 0; f--) begin
      for (int j = 0; j < 8; j++) begin
        op = '0;
        op.next_eip = NEXT_EIP;
        op.op0 = 32'h80 + j;
        op.seg = FAR_SEG;
        op.opcode = j[2] ? 16'h7700 : 16'h7500;
        op.opsize = jump_pkg::OPSZ_32;
        op.zf_en = j[1];
        op.cf_en = j[0];
        op.predicted_taken = f[1] ^ j[0];
        if (j == 0) begin
          cur_zf = f[1];
          cur_cf = f[0];
        end
        row_name[n_rows] = $sformatf("sweep_%h_zf%0d_cf%0d_en%0d",
                                     op.opcode[15:8], f[1], f[0], j[1:0]);
        row_flags[n_rows] = (j == 0) ? {1'b1, f[1:0]} : 3'b000;
        row_op[n_rows] = op;
        row_exp[n_rows] = model_resolve(op, cur_zf, cur_cf);
        n_rows++;
      end
    end
  endtask

  task automatic add_random_row(input int k);
    jump_pkg::jump_op_t op;
    case (k % 5)
      0: op.opcode = 16'hE900;
      1: op.opcode = 16'h7500;
      2: op.opcode = 16'hEA00;
      3: op.opcode = 16'hFF00;
      default: op.opcode = 16'h7700;
    endcase
    rng_state = lcg_next(rng_state);
    op.op0 = rng_state;
    rng_state = lcg_next(rng_state);
    op.next_eip = {16'h0, rng_state[31:16]};
    op.seg = {16'h0, rng_state[15:0]};
    op.opsize = jump_pkg::opsize_e'(rng_state[18:16]);
    op.alu_op = rng_state[21:19];
    op.zf_en = rng_state[24];
    op.cf_en = rng_state[25];
    op.predicted_taken = rng_state[26];
    row_name[n_rows] = $sformatf("random_%0d", k);
    row_flags[n_rows] = 3'b000;
    row_op[n_rows] = op;
    row_exp[n_rows] = model_resolve(op, cur_zf, cur_cf);
    n_rows++;
  endtask

  task automatic check_value(input string name, input string what,
                             input logic [31:0] exp, input logic [31:0] act);
    if (act !== exp) begin
      $display("FAILED %s %s: expected %h, actual %h", name, what, exp, act);
      errors++;
    end
  endtask

  task automatic check_outputs(input int i);
    check_value(row_name[i], "target", row_exp[i].target, redirect_target_o);
    check_value(row_name[i], "load_address", row_exp[i].load_address, redirect_load_address_o);
    check_value(row_name[i], "load_cs", row_exp[i].load_cs, redirect_load_cs_o);
    check_value(row_name[i], "mispredict", row_exp[i].mispredict, redirect_mispredict_o);
    check_value(row_name[i], "next_eip", row_exp[i].next_eip, redirect_next_eip_o);
    check_value(row_name[i], "seg", row_exp[i].seg, redirect_seg_o);
    // committed state still shows the earlier redirects.
    check_value(row_name[i], "eip", m_eip, eip_o);
    check_value(row_name[i], "cs", m_cs, cs_o);
    check_value(row_name[i], "mispredict_count", m_count, mispredict_count_o);
    m_eip = row_exp[i].load_address ? row_exp[i].target : row_exp[i].next_eip;
    if (row_exp[i].load_cs) begin
      m_cs = row_exp[i].seg;
    end
    if (row_exp[i].mispredict) begin
      m_count++;
    end
  endtask

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  initial begin
    #(TIMEOUT);
    $display("timeout, pipeline stalled after %0d of %0d redirects", out_count, NUM_ROWS);
    $display("Checks failed");
    $finish;
  end

  // output side with random ready.
  initial begin
    forever begin
      @(posedge clk);
      if (!reset_i && redirect_valid_o && redirect_ready_i) begin
        if (out_count >= NUM_ROWS) begin
          $display("redirect seen after all %0d rows were already received", NUM_ROWS);
          errors++;
        end else begin
          check_outputs(out_count);
          out_count++;
        end
      end
      rng_state = lcg_next(rng_state);
      redirect_ready_i <= (rng_state[17:16] != 2'b00);
    end
  end

  // ========================================
  initial begin
    errors = 0;
    out_count = 0;
    n_rows = 0;
    rng_state = 32'd39;
    cur_zf = 1'b0;
    cur_cf = 1'b0;
    m_eip = `JUMP_RESET_EIP;
    m_cs = `JUMP_RESET_CS;
    m_count = '0;
    reset_i = 1'b1;
    op_valid_i = 1'b0;
    op_next_eip_i = '0;
    op_op0_i = '0;
    op_seg_i = '0;
    op_opcode_i = '0;
    op_opsize_i = '0;
    op_alu_op_i = '0;
    op_zf_en_i = 1'b0;
    op_cf_en_i = 1'b0;
    op_predicted_taken_i = 1'b0;
    flags_we_i = 1'b0;
    zf_i = 1'b0;
    cf_i = 1'b0;
    redirect_ready_i = 1'b1;

    // name, flags, opcode, size, alu_op, {zf_en, cf_en}, predicted, op0, target, {la, lcs, mp}.
    add_row("jne_taken", 3'b101, 16'h7500, 3, 0, 2'b10, 1, 'h40, 'h1270, 3'b100);
    add_row("jne_cf_qual", 3'b000, 16'h7500, 3, 0, 2'b11, 1, 'h40, 'h0, 3'b001);
    add_row("jnbe_zf_set", 3'b110, 16'h7700, 3, 0, 2'b00, 0, 'h40, 'h0, 3'b000);
    add_row("jne_zf_set", 3'b000, 16'h7500, 3, 0, 2'b10, 1, 'h40, 'h0, 3'b001);
    add_row("jnbe_taken", 3'b100, 16'h7700, 3, 0, 2'b00, 0, 'h40, 'h1270, 3'b101);
    add_row("jcc_0f", 3'b000, 16'h0F85, 3, 0, 2'b11, 1, 'h100, 'h1330, 3'b100);
    add_row("jmp_rel8", 3'b000, 16'hEB00, 3, 0, 2'b00, 1, 'h10, 'h1240, 3'b100);
    add_row("rel32_np", 3'b000, 16'hE900, 3, 0, 2'b00, 0, 'h1234_5678, 'h1234_68A8, 3'b101);
    add_row("jmp_ind", 3'b000, 16'hFF00, 3, 6, 2'b00, 1, 'h8000, 'h8000, 3'b100);
    add_row("grp5_other", 3'b000, 16'hFF00, 3, 2, 2'b00, 1, 'h8000, 'h0, 3'b000);
    add_row("jmp_far", 3'b000, 16'hEA00, 3, 0, 2'b00, 1, 'h4000, 'h4000, 3'b110);
    add_row("size_16", 3'b000, 16'hE900, 2, 0, 2'b00, 1, 'h1234_5678, 'h68A8, 3'b100);
    add_row("size_8", 3'b000, 16'hE900, 1, 0, 2'b00, 1, 'h1234_5678, 'hA8, 3'b100);
    add_row("size_none", 3'b000, 16'hE900, 0, 0, 2'b00, 1, 'h1234_5678, 'h0, 3'b100);
    add_row("size_6", 3'b000, 16'hE900, 6, 0, 2'b00, 1, 'h1234_5678, 'h0, 3'b100);
    add_row("not_a_jump", 3'b000, 16'h9000, 3, 0, 2'b00, 0, 'h40, 'h0, 3'b000);
    add_cond_sweep();
    for (int k = 0; k < NUM_ROWS - NUM_FIXED - NUM_SWEEP; k++) begin
      add_random_row(k);
    end

    repeat (2) @(posedge clk);
    reset_i <= 1'b0;
    @(posedge clk);
    check_value("reset", "op_ready", 1'b1, op_ready_o);
    check_value("reset", "redirect_valid", 1'b0, redirect_valid_o);
    check_value("reset", "eip", `JUMP_RESET_EIP, eip_o);
    check_value("reset", "cs", `JUMP_RESET_CS, cs_o);
    check_value("reset", "mispredict_count", 0, mispredict_count_o);

    for (int i = 0; i < NUM_ROWS; i++) begin
      // flags only change with the pipeline empty.
      if (row_flags[i][2]) begin
        op_valid_i <= 1'b0;
        do @(negedge clk); while (out_count != i);
        @(posedge clk);
        flags_we_i <= 1'b1;
        zf_i <= row_flags[i][1];
        cf_i <= row_flags[i][0];
        @(posedge clk);
        flags_we_i <= 1'b0;
      end
      op_valid_i <= 1'b1;
      op_next_eip_i <= row_op[i].next_eip;
      op_op0_i <= row_op[i].op0;
      op_seg_i <= row_op[i].seg;
      op_opcode_i <= row_op[i].opcode;
      op_opsize_i <= row_op[i].opsize;
      op_alu_op_i <= row_op[i].alu_op;
      op_zf_en_i <= row_op[i].zf_en;
      op_cf_en_i <= row_op[i].cf_en;
      op_predicted_taken_i <= row_op[i].predicted_taken;
      @(posedge clk);
      while (!op_ready_o) @(posedge clk);
    end
    op_valid_i <= 1'b0;

    do @(negedge clk); while (out_count != NUM_ROWS);
    @(negedge clk);
    check_value("final", "eip", m_eip, eip_o);
    check_value("final", "cs", m_cs, cs_o);
    check_value("final", "mispredict_count", m_count, mispredict_count_o);
    $display("%0d errors over %0d rows", errors, NUM_ROWS);
    if (errors == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

endmodule

// ==== jump_subsystem.f ====
+incdir+verilog
verilog/jump_pkg.sv
verilog/stage_reg.sv
verilog/flag_reg.sv
verilog/jump_unit.sv
verilog/commit_state.sv
verilog/jump_subsystem.sv
bench/jump_props.sv
bench/jump_tb.sv

// ==== verilog/commit_state.sv ====
`include "jump_settings.svh"

module commit_state (
  input  logic                    clk,
  input  logic                    reset_i,

  input  logic                    fire_i,
  input  jump_pkg::redirect_t     redirect_i,

  output logic [`JUMP_ADDR_W-1:0] eip_o,
  output logic [`JUMP_ADDR_W-1:0] cs_o,
  output logic [`JUMP_CNT_W-1:0]  mispredict_count_o
);

  logic [`JUMP_ADDR_W-1:0] eip_q;
  logic [`JUMP_ADDR_W-1:0] cs_q;
  logic [`JUMP_CNT_W-1:0]  count_q;
  logic                    count_max;

  // ========================================
  // architectural eip and cs.

  always_ff @(posedge clk) begin
    if (reset_i) begin
      eip_q <= `JUMP_RESET_EIP;
      cs_q  <= `JUMP_RESET_CS;
    end else if (fire_i) begin
      if (redirect_i.load_address) begin
        eip_q <= redirect_i.target;
      end else begin
        eip_q <= redirect_i.next_eip;
      end
      if (redirect_i.load_cs) begin
        cs_q <= redirect_i.seg;
      end
    end
  end

  // ========================================
  // misprediction counter, saturating.

  assign count_max = &count_q;

  always_ff @(posedge clk) begin
    if (reset_i) begin
      count_q <= '0;
    end else if (fire_i && redirect_i.mispredict && !count_max) begin
      count_q <= count_q + 1'b1;
    end
  end

  assign eip_o              = eip_q;
  assign cs_o               = cs_q;
  assign mispredict_count_o = count_q;

endmodule

// ==== verilog/flag_reg.sv ====
module flag_reg (
  input  logic clk,
  input  logic reset_i,

  // write port.
  input  logic we_i,
  input  logic zf_i,
  input  logic cf_i,

  // high while an op waits for resolution.
  input  logic busy_i,

  output logic zf_o,
  output logic cf_o
);

  logic zf_q;
  logic cf_q;
  logic write_en;

  // flags must not move under an op that is being resolved.
  assign write_en = we_i && !busy_i;

  always_ff @(posedge clk) begin
    if (reset_i) begin
      zf_q <= 1'b0;
      cf_q <= 1'b0;
    end else if (write_en) begin
      zf_q <= zf_i;
      cf_q <= cf_i;
    end
  end

  assign zf_o = zf_q;
  assign cf_o = cf_q;

endmodule

// ==== verilog/jump_pkg.sv ====
`include "jump_settings.svh"

package jump_pkg;

  // ========================================
  // opcode constants, upper byte.
  localparam logic [7:0] OPC_JCC0F = 8'h0F;
  localparam logic [7:0] OPC_JNE = 8'h75;
  localparam logic [7:0] OPC_JNBE = 8'h77;
  localparam logic [7:0] OPC_JMP_REL8 = 8'hEB;
  localparam logic [7:0] OPC_JMP_REL32 = 8'hE9;
  localparam logic [7:0] OPC_JMP_FAR = 8'hEA;
  localparam logic [7:0] OPC_GRP5 = 8'hFF;

  // 0xff is only an indirect jump with this alu_op.
  localparam logic [2:0] ALU_OP_JMP_IND = 3'd6;

  // codes 4 to 7 are unused and mask to zero.
  typedef enum logic [2:0] {
    OPSZ_NONE = 3'd0,
    OPSZ_8 = 3'd1,
    OPSZ_16 = 3'd2,
    OPSZ_32 = 3'd3
  } opsize_e;

  // ========================================
  typedef struct packed {
    logic [`JUMP_ADDR_W-1:0] next_eip;
    logic [`JUMP_ADDR_W-1:0] op0;
    logic [`JUMP_ADDR_W-1:0] seg;
    logic [15:0] opcode;
    opsize_e opsize;
    logic [2:0] alu_op;
    logic zf_en;
    logic cf_en;
    logic predicted_taken;
  } jump_op_t;

  typedef struct packed {
    logic [`JUMP_ADDR_W-1:0] next_eip;
    logic [`JUMP_ADDR_W-1:0] target;
    logic [`JUMP_ADDR_W-1:0] seg;
    logic load_address;
    logic load_cs;
    logic mispredict;
  } redirect_t;

endpackage

// ==== verilog/jump_settings.svh ====
`ifndef JUMP_SETTINGS_SVH
`define JUMP_SETTINGS_SVH

// width of eip, operands and targets.
`define JUMP_ADDR_W 32

// committed state after reset.
`define JUMP_RESET_EIP 32'h0000_FFF0
`define JUMP_RESET_CS 32'h0000_F000

// misprediction counter width.
`define JUMP_CNT_W 16

`endif

// ==== verilog/jump_subsystem.sv ====
`include "jump_settings.svh"

module jump_subsystem (
  input  logic                    clk,
  input  logic                    reset_i,

  // decoded op.
  input  logic                    op_valid_i,
  output logic                    op_ready_o,
  input  logic [`JUMP_ADDR_W-1:0] op_next_eip_i,
  input  logic [`JUMP_ADDR_W-1:0] op_op0_i,
  input  logic [`JUMP_ADDR_W-1:0] op_seg_i,
  input  logic [15:0]             op_opcode_i,
  input  logic [2:0]              op_opsize_i,
  input  logic [2:0]              op_alu_op_i,
  input  logic                    op_zf_en_i,
  input  logic                    op_cf_en_i,
  input  logic                    op_predicted_taken_i,

  // flag write port.
  input  logic                    flags_we_i,
  input  logic                    zf_i,
  input  logic                    cf_i,

  // resolved redirect.
  output logic                    redirect_valid_o,
  input  logic                    redirect_ready_i,
  output logic [`JUMP_ADDR_W-1:0] redirect_next_eip_o,
  output logic [`JUMP_ADDR_W-1:0] redirect_target_o,
  output logic [`JUMP_ADDR_W-1:0] redirect_seg_o,
  output logic                    redirect_load_address_o,
  output logic                    redirect_load_cs_o,
  output logic                    redirect_mispredict_o,

  // committed state.
  output logic [`JUMP_ADDR_W-1:0] eip_o,
  output logic [`JUMP_ADDR_W-1:0] cs_o,
  output logic [`JUMP_CNT_W-1:0]  mispredict_count_o
);

  jump_pkg::jump_op_t  op_in;
  jump_pkg::jump_op_t  op_q;
  jump_pkg::redirect_t redirect_d;
  jump_pkg::redirect_t redirect_q;

  logic op_q_valid;
  logic redirect_in_ready;
  logic zf;
  logic cf;
  logic fire;

  assign op_in = '{
    next_eip:        op_next_eip_i,
    op0:             op_op0_i,
    seg:             op_seg_i,
    opcode:          op_opcode_i,
    opsize:          jump_pkg::opsize_e'(op_opsize_i),
    alu_op:          op_alu_op_i,
    zf_en:           op_zf_en_i,
    cf_en:           op_cf_en_i,
    predicted_taken: op_predicted_taken_i
  };

  // ========================================
  stage_reg #(.payload_t(jump_pkg::jump_op_t)) op_stage (
    .clk         (clk),
    .reset_i     (reset_i),
    .in_valid_i  (op_valid_i),
    .in_ready_o  (op_ready_o),
    .in_data_i   (op_in),
    .out_valid_o (op_q_valid),
    .out_ready_i (redirect_in_ready),
    .out_data_o  (op_q)
  );

  // an op in op_stage blocks flag writes.
  flag_reg u_flag_reg (
    .clk     (clk),
    .reset_i (reset_i),
    .we_i    (flags_we_i),
    .zf_i    (zf_i),
    .cf_i    (cf_i),
    .busy_i  (op_q_valid),
    .zf_o    (zf),
    .cf_o    (cf)
  );

  jump_unit u_jump_unit (
    .op_i       (op_q),
    .zf_i       (zf),
    .cf_i       (cf),
    .redirect_o (redirect_d)
  );

  stage_reg #(.payload_t(jump_pkg::redirect_t)) redirect_stage (
    .clk         (clk),
    .reset_i     (reset_i),
    .in_valid_i  (op_q_valid),
    .in_ready_o  (redirect_in_ready),
    .in_data_i   (redirect_d),
    .out_valid_o (redirect_valid_o),
    .out_ready_i (redirect_ready_i),
    .out_data_o  (redirect_q)
  );

  // ========================================
  assign fire = redirect_valid_o && redirect_ready_i;

  commit_state u_commit_state (
    .clk                (clk),
    .reset_i            (reset_i),
    .fire_i             (fire),
    .redirect_i         (redirect_q),
    .eip_o              (eip_o),
    .cs_o               (cs_o),
    .mispredict_count_o (mispredict_count_o)
  );

  assign redirect_next_eip_o     = redirect_q.next_eip;
  assign redirect_target_o       = redirect_q.target;
  assign redirect_seg_o          = redirect_q.seg;
  assign redirect_load_address_o = redirect_q.load_address;
  assign redirect_load_cs_o      = redirect_q.load_cs;
  assign redirect_mispredict_o   = redirect_q.mispredict;

endmodule

// ==== verilog/jump_unit.sv ====
`include "jump_settings.svh"

module jump_unit (
  input  jump_pkg::jump_op_t  op_i,
  input  logic                zf_i,
  input  logic                cf_i,
  output jump_pkg::redirect_t redirect_o
);

  logic [7:0] opc_hi;
  logic       alu_is_ind;

  logic is_cond;
  logic is_rel;
  logic is_ind;
  logic is_far;
  logic is_uncond;

  logic jne;
  logic jnbe;
  logic cond;

  logic                    load_address;
  logic [`JUMP_ADDR_W-1:0] near_target;
  logic [`JUMP_ADDR_W-1:0] raw_target;
  logic [`JUMP_ADDR_W-1:0] masked_target;

  // ========================================
  // instruction classes.

  assign opc_hi     = op_i.opcode[15:8];
  assign alu_is_ind = (op_i.alu_op == jump_pkg::ALU_OP_JMP_IND);

  assign is_cond = (opc_hi == jump_pkg::OPC_JNE) ||
                   (opc_hi == jump_pkg::OPC_JNBE) ||
                   (opc_hi == jump_pkg::OPC_JCC0F);

  assign is_rel = (opc_hi == jump_pkg::OPC_JMP_REL8) ||
                  (opc_hi == jump_pkg::OPC_JMP_REL32);

  assign is_ind = (opc_hi == jump_pkg::OPC_GRP5) && alu_is_ind;
  assign is_far = (opc_hi == jump_pkg::OPC_JMP_FAR);

  assign is_uncond = is_rel || is_ind || is_far;

  // ========================================
  // condition.

  // jne only counts when zf is the sole qualifier.
  assign jne  = op_i.zf_en && !op_i.cf_en && !zf_i;
  assign jnbe = !zf_i && !cf_i;
  assign cond = jne || jnbe;

  always_comb begin
    if (is_cond) begin
      load_address = cond;
    end else begin
      load_address = is_uncond;
    end
  end

  // ========================================
  // target.

  assign near_target = op_i.next_eip + op_i.op0;

  always_comb begin
    raw_target = '0;
    if (load_address) begin
      if (is_cond || is_rel) begin
        raw_target = near_target;
      end else begin
        raw_target = op_i.op0;
      end
    end
  end

  // truncate to the operand size.
  always_comb begin
    case (op_i.opsize)
      jump_pkg::OPSZ_32: masked_target = raw_target;
      jump_pkg::OPSZ_16: masked_target = {{(`JUMP_ADDR_W-16){1'b0}}, raw_target[15:0]};
      jump_pkg::OPSZ_8:  masked_target = {{(`JUMP_ADDR_W-8){1'b0}}, raw_target[7:0]};
      default:           masked_target = '0;
    endcase
  end

  // ========================================
  // result.

  always_comb begin
    redirect_o.next_eip     = op_i.next_eip;
    redirect_o.target       = masked_target;
    redirect_o.load_address = load_address;
    redirect_o.load_cs      = is_far;
    redirect_o.seg          = is_far ? op_i.seg : '0;

    // unconditional jumps are always taken.
    if (is_cond) begin
      redirect_o.mispredict = cond ^ op_i.predicted_taken;
    end else if (is_uncond) begin
      redirect_o.mispredict = !op_i.predicted_taken;
    end else begin
      redirect_o.mispredict = 1'b0;
    end
  end

endmodule

// ==== verilog/stage_reg.sv ====
module stage_reg #(
  parameter type payload_t = logic
) (
  input  logic     clk,
  input  logic     reset_i,

  input  logic     in_valid_i,
  output logic     in_ready_o,
  input  payload_t in_data_i,

  output logic     out_valid_o,
  input  logic     out_ready_i,
  output payload_t out_data_o
);

  logic     valid_q;
  payload_t data_q;

  // a full entry can be replaced in the same cycle it drains.
  assign in_ready_o = !valid_q || out_ready_i;

  always_ff @(posedge clk) begin
    if (reset_i) begin
      valid_q <= 1'b0;
    end else if (in_ready_o) begin
      valid_q <= in_valid_i;
    end
  end

  always_ff @(posedge clk) begin
    if (in_valid_i && in_ready_o) begin
      data_q <= in_data_i;
    end
  end

  assign out_valid_o = valid_q;
  assign out_data_o  = data_q;

endmodule
